/* Makefile */
# Verilator build and run for the RX descriptor scheduler

VERILATOR ?= verilator
TOP       ?= rx_scheduler_tb
FILELIST  ?= rx_scheduler.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(EXE)
	-./$(EXE) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* desc_allocator.sv */
`timescale 1ns/1ps

module desc_allocator import sched_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic                                  grant_valid,
  input  logic [IF_WIDTH-1:0]                   grant_port,
  input  logic [CORE_ID_WIDTH-1:0]              grant_core,
  input  logic [IF_COUNT-1:0][HASH_WIDTH-1:0]   hash,
  input  logic [CORE_COUNT-1:0]                 slot_avail,
  input  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] head_slot,
  input  logic [CORE_COUNT-1:0]                 income_cores,
  input  logic [IF_COUNT-1:0]                   almost_full,
  output logic [CORE_COUNT-1:0]                 slot_pop,
  output logic [IF_COUNT-1:0]                   hash_pop,
  output logic                                  desc_valid,
  output logic [IF_WIDTH-1:0]                   desc_port,
  output logic [CORE_ID_WIDTH-1:0]              desc_core,
  output logic [SLOT_WIDTH-1:0]                 desc_slot,
  output logic [HASH_WIDTH-1:0]                 desc_hash,
  output logic                                  desc_drop,
  output logic [IF_COUNT-1:0][CNT_WIDTH-1:0]    drop_count
);

  logic core_ok;
  logic alloc;
  logic drop;

  // Core must have a free slot and accept traffic from the interfaces
  assign core_ok = slot_avail[grant_core] && income_cores[grant_core];
  assign alloc   = grant_valid && core_ok;

  // No slot, drop only when the RX buffer is close to full
  assign drop = grant_valid && !core_ok && almost_full[grant_port];

  assign slot_pop = alloc ? (CORE_COUNT'(1) << grant_core) : '0;

  // Neither case leaves the hash waiting for a retry
  assign hash_pop = (alloc || drop) ? (IF_COUNT'(1) << grant_port) : '0;

  assign desc_valid = alloc || drop;
  assign desc_port  = grant_port;
  assign desc_core  = grant_core;
  assign desc_slot  = alloc ? head_slot[grant_core] : '0;
  assign desc_hash  = hash[grant_port];
  assign desc_drop  = drop;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      drop_count <= '0;
    end else if (drop) begin
      drop_count[grant_port] <= drop_count[grant_port] + 1'b1;
    end
  end

  // Each descriptor pops exactly one hash, and no hash goes without one
  assert property (@(posedge clk) disable iff (rst_r)
    (desc_valid && $onehot(hash_pop)) || (!desc_valid && (hash_pop == '0)))
    else $error("hash pop does not match the descriptor strobe");

endmodule

/* host_regs.sv */
`timescale 1ns/1ps

module host_regs import sched_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic [31:0]                           host_cmd,
  input  logic [31:0]                           host_cmd_wr_data,
  input  logic                                  host_cmd_valid,
  input  logic [IF_COUNT-1:0][LINE_WIDTH-1:0]   line_count,
  input  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] slot_count,
  input  logic [IF_COUNT-1:0][CNT_WIDTH-1:0]    drop_count,
  output logic [31:0]                           host_cmd_rd_data,
  output logic [CORE_COUNT-1:0]                 enabled_cores,
  output logic [CORE_COUNT-1:0]                 income_cores,
  output logic [CORE_COUNT-1:0]                 slots_flush,
  output logic [IF_COUNT-1:0]                   almost_full
);

  logic                                wr_en_r;
  host_reg_t                           reg_sel_r;
  logic [CORE_ID_WIDTH-1:0]            core_idx_r;
  logic [IF_WIDTH-1:0]                 if_idx_r;
  logic [31:0]                         wr_data_r;
  logic [LINE_WIDTH-1:0]               drop_limit;
  logic [IF_COUNT-1:0][LINE_WIDTH-1:0] line_r;
  logic [31:0]                         rd_next;

  // Command fields, one cycle behind the host
  always_ff @(posedge clk) begin
    reg_sel_r  <= host_reg_t'({host_cmd[CMD_IF_BIT], host_cmd[CMD_REG_WIDTH-1:0]});
    core_idx_r <= host_cmd[CMD_IDX_LSB +: CORE_ID_WIDTH];
    if_idx_r   <= host_cmd[CMD_IDX_LSB +: IF_WIDTH];
    wr_data_r  <= host_cmd_wr_data;
    line_r     <= line_count;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_en_r <= 1'b0;
    end else begin
      wr_en_r <= host_cmd_valid && host_cmd[CMD_WR_BIT] && host_cmd[CMD_SCHED_BIT];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      drop_limit    <= DROP_LIMIT_RESET;
    end else begin
      // Flush lasts a single cycle
      slots_flush <= '0;
      if (wr_en_r) begin
        case (reg_sel_r)
          REG_ENABLE: begin
            // A core being disabled stops taking new packets
            enabled_cores <= wr_data_r[CORE_COUNT-1:0];
            income_cores  <= income_cores & wr_data_r[CORE_COUNT-1:0];
          end
          REG_INCOME: begin
            income_cores <= wr_data_r[CORE_COUNT-1:0] & enabled_cores;
          end
          REG_FLUSH: begin
            slots_flush <= wr_data_r[CORE_COUNT-1:0];
          end
          REG_DROP_LIMIT: begin
            drop_limit <= wr_data_r[LINE_WIDTH-1:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      almost_full <= '0;
    end else begin
      for (int i = 0; i < IF_COUNT; i++) begin
        almost_full[i] <= (line_r[i] >= drop_limit);
      end
    end
  end

  // Readback goes through two register stages
  always_ff @(posedge clk) begin
    case (reg_sel_r)
      REG_ENABLE:     rd_next <= 32'(enabled_cores);
      REG_INCOME:     rd_next <= 32'(income_cores);
      REG_SLOT_COUNT: rd_next <= 32'(slot_count[core_idx_r]);
      REG_DROP_COUNT: begin
        if (if_idx_r < IF_WIDTH'(IF_COUNT)) begin
          rd_next <= 32'(drop_count[if_idx_r]);
        end else begin
          rd_next <= RD_DEFAULT;
        end
      end
      default:        rd_next <= RD_DEFAULT;
    endcase
    host_cmd_rd_data <= rd_next;
  end

endmodule

/* port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter import sched_pkg::*; (
  input  logic                                clk,
  input  logic                                rst_r,
  input  logic [IF_COUNT-1:0]                 hash_valid,
  input  logic [IF_COUNT-1:0][HASH_WIDTH-1:0] hash,
  input  logic [IF_COUNT-1:0]                 hash_pop,
  output logic                                grant_valid,
  output logic [IF_WIDTH-1:0]                 grant_port,
  output logic [CORE_ID_WIDTH-1:0]            grant_core
);

  logic [IF_COUNT-1:0] last_grant;
  logic [IF_COUNT-1:0] req;
  logic [IF_WIDTH-1:0] last_port;
  logic                win_valid;
  logic [IF_WIDTH-1:0] win_port;

  // The port granted last cycle is still being decided downstream
  assign last_grant = grant_valid ? (IF_COUNT'(1) << grant_port) : '0;

  // A hash being popped shows a stale valid this cycle
  assign req = hash_valid & ~last_grant & ~hash_pop;

  // Search starts just after the last winner
  always_comb begin
    int idx;
    win_valid = 1'b0;
    win_port  = '0;
    for (int k = 1; k <= IF_COUNT; k++) begin
      idx = (int'(last_port) + k) % IF_COUNT;
      if (!win_valid && req[idx]) begin
        win_valid = 1'b1;
        win_port  = IF_WIDTH'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_valid <= 1'b0;
      grant_port  <= '0;
      grant_core  <= '0;
      last_port   <= IF_WIDTH'(IF_COUNT - 1);
    end else begin
      grant_valid <= win_valid;
      if (win_valid) begin
        grant_port <= win_port;
        grant_core <= hash[win_port][HASH_SEL_OFFSET +: CORE_ID_WIDTH];
        last_port  <= win_port;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst_r)
    grant_valid |=> !grant_valid || (grant_port != $past(grant_port)))
    else $error("port granted in two consecutive cycles");

endmodule

/* rx_scheduler.f */
sched_pkg.sv
slot_keeper.sv
slot_pool.sv
port_arbiter.sv
desc_allocator.sv
host_regs.sv
rx_scheduler.sv
tb_clock.sv
rx_scheduler_tb.sv

/* rx_scheduler.sv */
`timescale 1ns/1ps

module rx_scheduler import sched_pkg::*; (
  input  logic                                clk,
  input  logic                                rst_r,
  input  logic [IF_COUNT-1:0]                 hash_valid,
  input  logic [IF_COUNT-1:0][HASH_WIDTH-1:0] hash,
  input  logic [IF_COUNT-1:0][LINE_WIDTH-1:0] line_count,
  output logic [IF_COUNT-1:0]                 hash_pop,
  input  logic                                slot_msg_valid,
  input  slot_msg_t                           slot_msg_type,
  input  logic [CORE_ID_WIDTH-1:0]            slot_msg_core,
  input  logic [SLOT_WIDTH-1:0]               slot_msg_slot,
  input  logic [31:0]                         host_cmd,
  input  logic [31:0]                         host_cmd_wr_data,
  input  logic                                host_cmd_valid,
  output logic [31:0]                         host_cmd_rd_data,
  output logic                                desc_valid,
  output logic [IF_WIDTH-1:0]                 desc_port,
  output logic [CORE_ID_WIDTH-1:0]            desc_core,
  output logic [SLOT_WIDTH-1:0]               desc_slot,
  output logic [HASH_WIDTH-1:0]               desc_hash,
  output logic                                desc_drop
);

  logic                                  grant_valid;
  logic [IF_WIDTH-1:0]                   grant_port;
  logic [CORE_ID_WIDTH-1:0]              grant_core;
  logic [CORE_COUNT-1:0]                 slot_avail;
  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] head_slot;
  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] slot_count;
  logic [CORE_COUNT-1:0]                 slot_pop;
  logic [IF_COUNT-1:0][CNT_WIDTH-1:0]    drop_count;
  logic [CORE_COUNT-1:0]                 enabled_cores;
  logic [CORE_COUNT-1:0]                 income_cores;
  logic [CORE_COUNT-1:0]                 slots_flush;
  logic [IF_COUNT-1:0]                   almost_full;

  host_regs host_regs0 (
    .clk(clk), .rst_r(rst_r),
    .host_cmd(host_cmd), .host_cmd_wr_data(host_cmd_wr_data),
    .host_cmd_valid(host_cmd_valid), .line_count(line_count),
    .slot_count(slot_count), .drop_count(drop_count),
    .host_cmd_rd_data(host_cmd_rd_data), .enabled_cores(enabled_cores),
    .income_cores(income_cores), .slots_flush(slots_flush), .almost_full(almost_full)
  );

  slot_pool slot_pool0 (
    .clk(clk), .rst_r(rst_r),
    .slot_msg_valid(slot_msg_valid), .slot_msg_type(slot_msg_type),
    .slot_msg_core(slot_msg_core), .slot_msg_slot(slot_msg_slot),
    .enabled_cores(enabled_cores), .slots_flush(slots_flush), .slot_pop(slot_pop),
    .slot_avail(slot_avail), .head_slot(head_slot), .slot_count(slot_count)
  );

  port_arbiter port_arbiter0 (
    .clk(clk), .rst_r(rst_r),
    .hash_valid(hash_valid), .hash(hash), .hash_pop(hash_pop),
    .grant_valid(grant_valid), .grant_port(grant_port), .grant_core(grant_core)
  );

  desc_allocator desc_allocator0 (
    .clk(clk), .rst_r(rst_r),
    .grant_valid(grant_valid), .grant_port(grant_port), .grant_core(grant_core),
    .hash(hash), .slot_avail(slot_avail), .head_slot(head_slot),
    .income_cores(income_cores), .almost_full(almost_full),
    .slot_pop(slot_pop), .hash_pop(hash_pop), .desc_valid(desc_valid),
    .desc_port(desc_port), .desc_core(desc_core), .desc_slot(desc_slot),
    .desc_hash(desc_hash), .desc_drop(desc_drop), .drop_count(drop_count)
  );

endmodule

/* rx_scheduler_tb.sv */
`timescale 1ns/1ps

module rx_scheduler_tb import sched_pkg::*; ();

  localparam int ROW_CYCLES  = 40;
  localparam int HOLD_CYCLES = 12;

  typedef enum {OP_WRITE, OP_READ, OP_MSG, OP_HASH, OP_HOLD, OP_DRAIN} op_t;

  // Operands of a step and the readback it expects
  typedef struct {
    op_t         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] rd_exp;
  } step_t;

  logic                                clk;
  logic                                rst_r;
  logic [IF_COUNT-1:0]                 hash_valid;
  logic [IF_COUNT-1:0][HASH_WIDTH-1:0] hash;
  logic [IF_COUNT-1:0][LINE_WIDTH-1:0] line_count;
  logic [IF_COUNT-1:0]                 hash_pop;
  logic                                slot_msg_valid;
  slot_msg_t                           slot_msg_type;
  logic [CORE_ID_WIDTH-1:0]            slot_msg_core;
  logic [SLOT_WIDTH-1:0]               slot_msg_slot;
  logic [31:0]                         host_cmd;
  logic [31:0]                         host_cmd_wr_data;
  logic                                host_cmd_valid;
  logic [31:0]                         host_cmd_rd_data;
  logic                                desc_valid;
  logic [IF_WIDTH-1:0]                 desc_port;
  logic [CORE_ID_WIDTH-1:0]            desc_core;
  logic [SLOT_WIDTH-1:0]               desc_slot;
  logic [HASH_WIDTH-1:0]               desc_hash;
  logic                                desc_drop;

  // Hash queues per interface and the reference model of the scheduler
  step_t                 steps[$];
  logic [HASH_WIDTH-1:0] pending [IF_COUNT][$];
  logic [SLOT_WIDTH-1:0] model_slots [CORE_COUNT][$];
  logic [CORE_COUNT-1:0] model_enable;
  logic [CORE_COUNT-1:0] model_income;
  logic [LINE_WIDTH-1:0] model_limit;
  logic [LINE_WIDTH-1:0] model_line [IF_COUNT];
  logic [31:0]           rand_state;

  tb_clock clock0 (.clk(clk), .rst_r(rst_r));

  rx_scheduler dut0 (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_with(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      stop_with($sformatf("Fail %s got %h expected %h", name, got, want));
    end
  endtask

  function automatic logic [31:0] make_cmd(input logic wr, input logic [31:0] code,
                                           input logic [31:0] idx);
    logic [31:0] cmd;
    cmd = {28'd0, code[3:0]} | ({28'd0, idx[3:0]} << CMD_IDX_LSB);
    cmd[CMD_WR_BIT]    = wr;
    cmd[CMD_IF_BIT]    = code[4];
    cmd[CMD_SCHED_BIT] = 1'b1;
    return cmd;
  endfunction

  function automatic int waiting_hashes();
    int n;
    n = 0;
    for (int i = 0; i < IF_COUNT; i++) begin
      n += pending[i].size();
    end
    return n;
  endfunction

  // Checks a descriptor against the front hash of its interface
  task automatic scan_outputs(output logic [IF_COUNT-1:0] popped);
    logic [HASH_WIDTH-1:0]    h;
    logic [CORE_ID_WIDTH-1:0] c;
    logic [SLOT_WIDTH-1:0]    s;
    logic                     avail;
    logic [IF_COUNT-1:0]      want_pop;
    want_pop = '0;
    if (desc_valid) begin
      want_pop = IF_COUNT'(1) << desc_port;
      if (int'(desc_port) >= IF_COUNT || pending[desc_port].size() == 0) begin
        stop_with("descriptor for an interface with no waiting hash");
      end else begin
        h     = pending[desc_port][0];
        c     = h[HASH_SEL_OFFSET +: CORE_ID_WIDTH];
        avail = (model_slots[c].size() != 0) && model_enable[c] && model_income[c];
        compare("desc_hash", desc_hash, h);
        compare("desc_core", 32'(desc_core), 32'(c));
        compare("desc_drop", 32'(desc_drop), 32'(!avail));
        if (avail) begin
          s = model_slots[c].pop_front();
          compare("desc_slot", 32'(desc_slot), 32'(s));
        end else if (model_line[desc_port] < model_limit) begin
          stop_with("packet dropped while its line count was below the drop limit");
        end
      end
    end
    compare("hash_pop", 32'(hash_pop), 32'(want_pop));
    popped = hash_pop;
  endtask

  // Outputs are checked mid-cycle, inputs change 1 ns after the rising edge
  task automatic next_cycle();
    logic [IF_COUNT-1:0] popped;
    @(negedge clk);
    scan_outputs(popped);
    @(posedge clk);
    #1;
    for (int i = 0; i < IF_COUNT; i++) begin
      if (popped[i]) begin
        void'(pending[i].pop_front());
      end
      hash_valid[i] = (pending[i].size() != 0);
      hash[i]       = hash_valid[i] ? pending[i][0] : '0;
    end
  endtask

  task automatic host_write(input logic [31:0] code, idx, data);
    host_cmd         = make_cmd(1'b1, code, idx);
    host_cmd_wr_data = data;
    host_cmd_valid   = 1'b1;
    case (host_reg_t'(code[4:0]))
      REG_ENABLE: begin
        model_enable = data[CORE_COUNT-1:0];
        model_income = model_income & data[CORE_COUNT-1:0];
      end
      REG_INCOME: begin
        model_income = data[CORE_COUNT-1:0] & model_enable;
      end
      REG_FLUSH: begin
        for (int k = 0; k < CORE_COUNT; k++) begin
          if (data[k]) begin
            model_slots[k].delete();
          end
        end
      end
      REG_DROP_LIMIT: begin
        model_limit = data[LINE_WIDTH-1:0];
      end
      default: begin
      end
    endcase
    next_cycle();
    host_cmd_valid = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic host_read(input logic [31:0] code, idx, want);
    host_cmd       = make_cmd(1'b0, code, idx);
    host_cmd_valid = 1'b0;
    repeat (4) next_cycle();
    compare("host_cmd_rd_data", host_cmd_rd_data, want);
  endtask

  task automatic send_slot_msg(input logic [31:0] kind, core, slot);
    slot_msg_type  = slot_msg_t'(kind[1:0]);
    slot_msg_core  = core[CORE_ID_WIDTH-1:0];
    slot_msg_slot  = slot[SLOT_WIDTH-1:0];
    slot_msg_valid = 1'b1;
    if (kind[1:0] == MSG_SLOT_INIT) begin
      model_slots[slot_msg_core].delete();
      for (int k = 1; k <= int'(slot_msg_slot) && k <= SLOT_COUNT; k++) begin
        model_slots[slot_msg_core].push_back(SLOT_WIDTH'(k));
      end
    end else if (model_slots[slot_msg_core].size() < SLOT_COUNT) begin
      model_slots[slot_msg_core].push_back(slot_msg_slot);
    end
    next_cycle();
    slot_msg_valid = 1'b0;
    repeat (2) next_cycle();
  endtask

  // One new hash per selected interface, its low bits pick the core
  task automatic load_hashes(input logic [31:0] mask, core, lines);
    logic [HASH_WIDTH-1:0] h;
    for (int i = 0; i < IF_COUNT; i++) begin
      if (mask[i]) begin
        line_count[i] = lines[LINE_WIDTH-1:0];
        model_line[i] = lines[LINE_WIDTH-1:0];
      end
    end
    // Line count compare sits two registers deep
    repeat (3) next_cycle();
    for (int i = 0; i < IF_COUNT; i++) begin
      if (mask[i]) begin
        rand_state = xorshift(rand_state);
        h = rand_state;
        h[HASH_SEL_OFFSET +: CORE_ID_WIDTH] = core[CORE_ID_WIDTH-1:0];
        pending[i].push_back(h);
      end
    end
  endtask

  task automatic apply_step(input step_t s);
    case (s.op)
      OP_WRITE: host_write(s.a, s.b, s.c);
      OP_READ:  host_read(s.a, s.b, s.rd_exp);
      OP_MSG:   send_slot_msg(s.a, s.b, s.c);
      OP_HASH: begin
        load_hashes(s.a, s.b, s.c);
        while (waiting_hashes() != 0) next_cycle();
      end
      OP_HOLD: begin
        load_hashes(s.a, s.b, s.c);
        repeat (HOLD_CYCLES) next_cycle();
        compare("hash_valid", 32'(hash_valid), 32'(s.a[IF_COUNT-1:0]));
      end
      default: begin
        while (waiting_hashes() != 0) next_cycle();
      end
    endcase
  endtask

  task automatic add_step(input op_t op, input logic [31:0] a, b, c, rd_exp);
    steps.push_back('{op, a, b, c, rd_exp});
  endtask

  task automatic build_table();
    add_step(OP_READ,  32'(REG_ENABLE),     0, 0, 32'h0);
    add_step(OP_READ,  32'(REG_INCOME),     0, 0, 32'h0);
    add_step(OP_READ,  32'h07,              0, 0, RD_DEFAULT);
    add_step(OP_WRITE, 32'(REG_ENABLE),     0, 32'hB, 0);
    add_step(OP_WRITE, 32'(REG_INCOME),     0, 32'hF, 0);
    add_step(OP_READ,  32'(REG_INCOME),     0, 0, 32'hB);
    add_step(OP_WRITE, 32'(REG_ENABLE),     0, 32'h7, 0);
    add_step(OP_READ,  32'(REG_ENABLE),     0, 0, 32'h7);
    add_step(OP_READ,  32'(REG_INCOME),     0, 0, 32'h3);
    add_step(OP_MSG,   32'(MSG_SLOT_INIT),  0, 5, 0);
    add_step(OP_READ,  32'(REG_SLOT_COUNT), 0, 0, 32'h5);
    add_step(OP_MSG,   32'(MSG_SLOT_INIT),  1, 3, 0);
    add_step(OP_MSG,   32'(MSG_SLOT_FREE),  1, 7, 0);
    add_step(OP_READ,  32'(REG_SLOT_COUNT), 1, 0, 32'h4);
    add_step(OP_MSG,   32'(MSG_SLOT_INIT),  2, 2, 0);
    add_step(OP_HASH,  32'h7, 0, 32'h0, 0);
    add_step(OP_HASH,  32'h3, 1, 32'h0, 0);
    add_step(OP_READ,  32'(REG_SLOT_COUNT), 0, 0, 32'h2);
    add_step(OP_READ,  32'(REG_SLOT_COUNT), 1, 0, 32'h2);
    add_step(OP_HASH,  32'h5, 0, 32'h0, 0);
    // Core 0 is empty now, core 2 has slots but takes no traffic
    add_step(OP_HASH,  32'h1, 0, 32'hE00, 0);
    add_step(OP_HASH,  32'h2, 2, 32'h1FFF, 0);
    add_step(OP_READ,  32'(REG_DROP_COUNT), 0, 0, 32'h1);
    add_step(OP_READ,  32'(REG_DROP_COUNT), 1, 0, 32'h1);
    add_step(OP_READ,  32'(REG_DROP_COUNT), 2, 0, 32'h0);
    add_step(OP_WRITE, 32'(REG_DROP_LIMIT), 0, 32'h100, 0);
    add_step(OP_HASH,  32'h4, 0, 32'h100, 0);
    add_step(OP_READ,  32'(REG_DROP_COUNT), 2, 0, 32'h1);
    // Below the limit the hash waits for a returned slot
    add_step(OP_HOLD,  32'h4, 0, 32'hFF, 0);
    add_step(OP_MSG,   32'(MSG_SLOT_FREE),  0, 6, 0);
    add_step(OP_DRAIN, 0, 0, 0, 0);
    add_step(OP_READ,  32'(REG_SLOT_COUNT), 0, 0, 32'h0);
    add_step(OP_WRITE, 32'(REG_FLUSH),      0, 32'h2, 0);
    add_step(OP_READ,  32'(REG_SLOT_COUNT), 1, 0, 32'h0);
    add_step(OP_READ,  32'(REG_SLOT_COUNT), 2, 0, 32'h2);
  endtask

  initial begin
    hash_valid       = '0;
    hash             = '0;
    line_count       = '0;
    slot_msg_valid   = 1'b0;
    slot_msg_type    = MSG_SLOT_FREE;
    slot_msg_core    = '0;
    slot_msg_slot    = '0;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    model_enable     = '0;
    model_income     = '0;
    model_limit      = DROP_LIMIT_RESET;
    for (int i = 0; i < IF_COUNT; i++) begin
      model_line[i] = '0;
    end
    rand_state = 32'hd8bb;
    build_table();
    wait (!rst_r);
    next_cycle();
    foreach (steps[n]) begin
      apply_step(steps[n]);
    end
    repeat (4) next_cycle();
    if (waiting_hashes() != 0) begin
      stop_with("hashes still waiting at the end of the run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  // Watchdog sized from the table length
  initial begin
    #1;
    repeat (ROW_CYCLES * steps.size() + 10) @(posedge clk);
    stop_with("timeout, the table of steps did not finish in time");
  end

endmodule

/* sched_pkg.sv */
package sched_pkg;

  // Interfaces and cores
  localparam int IF_COUNT      = 3;
  localparam int IF_WIDTH      = 2;
  localparam int CORE_COUNT    = 4;
  localparam int CORE_ID_WIDTH = 2;

  // Free slots per core, count needs to hold 0 to SLOT_COUNT
  localparam int SLOT_COUNT     = 8;
  localparam int SLOT_WIDTH     = 4;
  localparam int SLOT_PTR_WIDTH = 3;

  // Flow hash and core selection
  localparam int HASH_WIDTH      = 32;
  localparam int HASH_SEL_OFFSET = 0;

  // RX buffer fill and drop accounting
  localparam int                    LINE_WIDTH       = 13;
  localparam logic [LINE_WIDTH-1:0] DROP_LIMIT_RESET = 13'hE00;
  localparam int                    CNT_WIDTH        = 32;

  // Host command word
  localparam logic [31:0] RD_DEFAULT    = 32'hFEFEFEFE;
  localparam int          CMD_WR_BIT    = 31;
  localparam int          CMD_IF_BIT    = 30;
  localparam int          CMD_SCHED_BIT = 29;
  localparam int          CMD_IDX_LSB   = 4;
  localparam int          CMD_REG_WIDTH = 4;

  // Slot messages from the cores
  typedef enum logic [1:0] {
    MSG_SLOT_FREE = 2'd0,
    MSG_SLOT_INIT = 2'd3
  } slot_msg_t;

  // Host registers, top bit selects the interface bank
  typedef enum logic [4:0] {
    REG_ENABLE     = 5'h00,
    REG_INCOME     = 5'h01,
    REG_FLUSH      = 5'h02,
    REG_SLOT_COUNT = 5'h03,
    REG_DROP_COUNT = 5'h12,
    REG_DROP_LIMIT = 5'h13
  } host_reg_t;

endpackage

/* slot_keeper.sv */
`timescale 1ns/1ps

module slot_keeper import sched_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  flush,
  input  logic [SLOT_WIDTH-1:0] init_count,
  input  logic                  init_valid,
  input  logic [SLOT_WIDTH-1:0] slot_in,
  input  logic                  slot_in_valid,
  output logic [SLOT_WIDTH-1:0] slot_out,
  output logic                  slot_out_valid,
  input  logic                  slot_out_pop,
  output logic [SLOT_WIDTH-1:0] slot_count,
  output logic                  enq_err
);

  logic [SLOT_WIDTH-1:0]     mem [SLOT_COUNT];
  logic [SLOT_PTR_WIDTH-1:0] rd_ptr;
  logic [SLOT_PTR_WIDTH-1:0] wr_ptr;
  logic [SLOT_WIDTH-1:0]     init_fill;
  logic                      full;
  logic                      do_enq;
  logic                      do_pop;

  assign full           = (slot_count == SLOT_WIDTH'(SLOT_COUNT));
  assign do_enq         = slot_in_valid && !full;
  assign do_pop         = slot_out_pop && slot_out_valid;
  assign slot_out       = mem[rd_ptr];
  assign slot_out_valid = (slot_count != '0);

  // Init asks for at most a full pool
  assign init_fill = (init_count > SLOT_WIDTH'(SLOT_COUNT)) ? SLOT_WIDTH'(SLOT_COUNT)
                                                            : init_count;

  // Init writes slots 1 to SLOT_COUNT, only the first init_fill are live
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int k = 0; k < SLOT_COUNT; k++) begin
        mem[k] <= SLOT_WIDTH'(k + 1);
      end
    end else if (do_enq) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_count <= '0;
      enq_err    <= 1'b0;
    end else if (init_valid) begin
      rd_ptr     <= '0;
      wr_ptr     <= init_fill[SLOT_PTR_WIDTH-1:0];
      slot_count <= init_fill;
    end else begin
      if (do_enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      slot_count <= slot_count + SLOT_WIDTH'(do_enq) - SLOT_WIDTH'(do_pop);
      // Sticky until reset or flush
      if (slot_in_valid && full) begin
        enq_err <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst_r) slot_out_pop |-> slot_out_valid)
    else $error("slot popped from an empty keeper");

endmodule

/* slot_pool.sv */
`timescale 1ns/1ps

module slot_pool import sched_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic                                  slot_msg_valid,
  input  slot_msg_t                             slot_msg_type,
  input  logic [CORE_ID_WIDTH-1:0]              slot_msg_core,
  input  logic [SLOT_WIDTH-1:0]                 slot_msg_slot,
  input  logic [CORE_COUNT-1:0]                 enabled_cores,
  input  logic [CORE_COUNT-1:0]                 slots_flush,
  input  logic [CORE_COUNT-1:0]                 slot_pop,
  output logic [CORE_COUNT-1:0]                 slot_avail,
  output logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] head_slot,
  output logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] slot_count
);

  logic [CORE_COUNT-1:0] init_v;
  logic [CORE_COUNT-1:0] enq_v;
  logic [CORE_COUNT-1:0] keeper_valid;
  logic [SLOT_WIDTH-1:0] msg_slot_r;

  // Per-core strobes, one cycle behind the message
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v <= '0;
      enq_v  <= '0;
    end else begin
      for (int i = 0; i < CORE_COUNT; i++) begin
        init_v[i] <= slot_msg_valid && (slot_msg_type == MSG_SLOT_INIT) &&
                     (slot_msg_core == CORE_ID_WIDTH'(i));
        enq_v[i]  <= slot_msg_valid && (slot_msg_type == MSG_SLOT_FREE) &&
                     (slot_msg_core == CORE_ID_WIDTH'(i));
      end
    end
  end

  // Slot number for free, slot count for init
  always_ff @(posedge clk) begin
    msg_slot_r <= slot_msg_slot;
  end

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_keeper
    slot_keeper keeper (
      .clk           (clk),
      .rst_r         (rst_r),
      .flush         (slots_flush[i]),
      .init_count    (msg_slot_r),
      .init_valid    (init_v[i]),
      .slot_in       (msg_slot_r),
      .slot_in_valid (enq_v[i]),
      .slot_out      (head_slot[i]),
      .slot_out_valid(keeper_valid[i]),
      .slot_out_pop  (slot_pop[i]),
      .slot_count    (slot_count[i]),
      .enq_err       ()
    );
  end

  // A disabled core offers no slots
  assign slot_avail = keeper_valid & enabled_cores;

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_r
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held for two rising edges
  initial begin
    rst_r = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst_r = 1'b0;
  end

endmodule
